//--- include/filt_ctrl_consts.svh
// Register map and field layout of the filter configuration block.
// Addresses are 5-bit word addresses on the register bus.
// Slots 3 and 19 to 23 are reserved and read as zero.
// Field positions apply to every channel CFG register.

`ifndef FILT_CTRL_CONSTS_SVH
`define FILT_CTRL_CONSTS_SVH

`define FILT_L2_AWIDTH  15       // Stream start address width
`define FILT_TRANS_SIZE 16       // Length field width
`define FILT_NUM_EVT    4
`define FILT_NUM_TX     2

//////////////////////////////////////////////////////////////////////
// Register addresses
//////////////////////////////////////////////////////////////////////
`define REG_CG          5'd0
`define REG_CFG_EVT     5'd1
`define REG_RST         5'd2

`define REG_TX0_ADD     5'd4
`define REG_TX0_CFG     5'd5
`define REG_TX0_LEN0    5'd6
`define REG_TX0_LEN1    5'd7
`define REG_TX0_LEN2    5'd8

`define REG_TX1_ADD     5'd9
`define REG_TX1_CFG     5'd10
`define REG_TX1_LEN0    5'd11
`define REG_TX1_LEN1    5'd12
`define REG_TX1_LEN2    5'd13

`define REG_RX_ADD      5'd14
`define REG_RX_CFG      5'd15
`define REG_RX_LEN0     5'd16
`define REG_RX_LEN1     5'd17
`define REG_RX_LEN2     5'd18

`define REG_FILT        5'd24
`define REG_FILT_CMD    5'd25

//////////////////////////////////////////////////////////////////////
// Field positions
//////////////////////////////////////////////////////////////////////
`define FILT_DSIZE_MSB  1
`define FILT_DSIZE_LSB  0
`define FILT_CMODE_MSB  9        // Channel mode in CFG
`define FILT_CMODE_LSB  8
`define FILT_FMODE_MSB  2        // Filter mode in REG_FILT
`define FILT_FMODE_LSB  0

`endif

//--- hw/filt_ctrl_pkg.sv
// Types shared by the filter configuration block and its testbench.
// Widths come from the constants header.
// Struct fields are packed MSB first in declaration order.

`include "filt_ctrl_consts.svh"

package filt_ctrl_pkg;

    // One register bus request, acted on while valid is high
    typedef struct packed
    {
        logic        valid;
        logic        rwn;                      // Set for read
        logic [4:0]  addr;
        logic [31:0] wdata;
    } cfg_req_t;

    // One stream channel
    typedef struct packed
    {
        logic [`FILT_L2_AWIDTH-1:0]  start_addr;
        logic [1:0]                  datasize;
        logic [1:0]                  mode;
        logic [`FILT_TRANS_SIZE-1:0] len0;
        logic [`FILT_TRANS_SIZE-1:0] len1;
        logic [`FILT_TRANS_SIZE-1:0] len2;
    } chan_cfg_t;

    // Complete stream setting handed to the filter
    typedef struct packed
    {
        chan_cfg_t [`FILT_NUM_TX-1:0] tx;
        chan_cfg_t                    rx;
        logic [2:0]                   filter_mode;
    } filt_cfg_t;

endpackage

//--- hw/filt_cfg_regfile.sv
// Register bank behind the configuration bus.
// Writes land at the clock edge of the valid cycle; reads are
// combinational and return zero outside a read cycle.
// The bus never stalls. Reserved and unmapped slots read zero.
// A write of bit 0 to the command register gives a one cycle strobe.

`timescale 1ns/1ns
`include "filt_ctrl_consts.svh"

module filt_cfg_regfile
(
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  filt_ctrl_pkg::cfg_req_t       cfg_req_i,
    output logic [31:0]                   cfg_rdata_o,
    output logic [15:0]                   cg_value_o,
    output logic                          cg_core_o,
    output logic [15:0]                   rst_value_o,
    output filt_ctrl_pkg::filt_cfg_t      shadow_cfg_o,
    output logic [`FILT_NUM_EVT-1:0][7:0] evt_codes_o,
    output logic                          cmd_start_o
);

    logic [15:0]                   r_cg;
    logic [15:0]                   r_rst;
    logic [`FILT_NUM_EVT-1:0][7:0] r_evt_codes;
    filt_ctrl_pkg::filt_cfg_t      r_shadow;
    logic                          r_cmd_start;

    logic                          s_wr_en;
    logic                          s_rd_en;
    logic                          s_chan_hit;
    logic [1:0]                    s_chan_idx;   // 0 tx0, 1 tx1, 2 rx
    logic [2:0]                    s_chan_ofs;
    filt_ctrl_pkg::chan_cfg_t      s_chan_cur;

    //////////////////////////////////////////////////////////////////////
    // Channel register access, offsets ADD CFG LEN0 LEN1 LEN2
    //////////////////////////////////////////////////////////////////////
    function automatic filt_ctrl_pkg::chan_cfg_t chan_write(
        input filt_ctrl_pkg::chan_cfg_t chan,
        input logic [2:0]               ofs,
        input logic [31:0]              data
    );
        filt_ctrl_pkg::chan_cfg_t upd;
        upd = chan;
        case (ofs)
            3'd0: upd.start_addr = data[`FILT_L2_AWIDTH-1:0];
            3'd1:
            begin
                upd.datasize = data[`FILT_DSIZE_MSB:`FILT_DSIZE_LSB];
                upd.mode     = data[`FILT_CMODE_MSB:`FILT_CMODE_LSB];
            end
            3'd2: upd.len0 = data[`FILT_TRANS_SIZE-1:0];
            3'd3: upd.len1 = data[`FILT_TRANS_SIZE-1:0];
            3'd4: upd.len2 = data[`FILT_TRANS_SIZE-1:0];
            default: upd = chan;
        endcase
        return upd;
    endfunction

    function automatic logic [31:0] chan_read(
        input filt_ctrl_pkg::chan_cfg_t chan,
        input logic [2:0]               ofs
    );
        logic [31:0] rd;
        rd = '0;
        case (ofs)
            3'd0: rd[`FILT_L2_AWIDTH-1:0] = chan.start_addr;
            3'd1:
            begin
                rd[`FILT_DSIZE_MSB:`FILT_DSIZE_LSB] = chan.datasize;
                rd[`FILT_CMODE_MSB:`FILT_CMODE_LSB] = chan.mode;
            end
            3'd2: rd[`FILT_TRANS_SIZE-1:0] = chan.len0;
            3'd3: rd[`FILT_TRANS_SIZE-1:0] = chan.len1;
            3'd4: rd[`FILT_TRANS_SIZE-1:0] = chan.len2;
            default: rd = '0;
        endcase
        return rd;
    endfunction

    assign s_wr_en = cfg_req_i.valid & ~cfg_req_i.rwn;
    assign s_rd_en = cfg_req_i.valid &  cfg_req_i.rwn;

    // Map address onto channel and offset
    always_comb
    begin
        s_chan_hit = 1'b1;
        s_chan_idx = 2'd0;
        s_chan_ofs = 3'(cfg_req_i.addr - `REG_TX0_ADD);
        if (cfg_req_i.addr >= `REG_RX_ADD && cfg_req_i.addr <= `REG_RX_LEN2)
        begin
            s_chan_idx = 2'd2;
            s_chan_ofs = 3'(cfg_req_i.addr - `REG_RX_ADD);
        end
        else if (cfg_req_i.addr >= `REG_TX1_ADD && cfg_req_i.addr <= `REG_TX1_LEN2)
        begin
            s_chan_idx = 2'd1;
            s_chan_ofs = 3'(cfg_req_i.addr - `REG_TX1_ADD);
        end
        else if (cfg_req_i.addr < `REG_TX0_ADD || cfg_req_i.addr > `REG_TX0_LEN2)
            s_chan_hit = 1'b0;
    end

    assign s_chan_cur = (s_chan_idx == 2'd2) ? r_shadow.rx : r_shadow.tx[s_chan_idx[0]];

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_cg        <= '0;
            r_rst       <= '0;
            r_evt_codes <= '0;
            r_shadow    <= '0;
            r_cmd_start <= 1'b0;
        end
        else
        begin
            r_cmd_start <= s_wr_en && (cfg_req_i.addr == `REG_FILT_CMD) && cfg_req_i.wdata[0];
            if (s_wr_en)
            begin
                case (cfg_req_i.addr)
                    `REG_CG:      r_cg        <= cfg_req_i.wdata[15:0];
                    `REG_RST:     r_rst       <= cfg_req_i.wdata[15:0];
                    `REG_CFG_EVT: r_evt_codes <= cfg_req_i.wdata;   // Code i in byte i
                    `REG_FILT:
                        r_shadow.filter_mode <= cfg_req_i.wdata[`FILT_FMODE_MSB:`FILT_FMODE_LSB];
                    default:
                    begin
                        if (s_chan_hit && s_chan_idx == 2'd2)
                            r_shadow.rx <= chan_write(s_chan_cur, s_chan_ofs, cfg_req_i.wdata);
                        else if (s_chan_hit)
                            r_shadow.tx[s_chan_idx[0]] <=
                                chan_write(s_chan_cur, s_chan_ofs, cfg_req_i.wdata);
                    end
                endcase
            end
        end
    end

    always_comb
    begin
        cfg_rdata_o = '0;
        if (s_rd_en)
        begin
            case (cfg_req_i.addr)
                `REG_CG:      cfg_rdata_o[15:0] = r_cg;
                `REG_RST:     cfg_rdata_o[15:0] = r_rst;
                `REG_CFG_EVT: cfg_rdata_o       = r_evt_codes;
                `REG_FILT:
                    cfg_rdata_o[`FILT_FMODE_MSB:`FILT_FMODE_LSB] = r_shadow.filter_mode;
                default:
                begin
                    if (s_chan_hit)
                        cfg_rdata_o = chan_read(s_chan_cur, s_chan_ofs);
                end
            endcase
        end
    end

    assign cg_value_o   = r_cg;
    assign cg_core_o    = |r_cg;              // Top gate on if any peripheral on
    assign rst_value_o  = r_rst;
    assign shadow_cfg_o = r_shadow;
    assign evt_codes_o  = r_evt_codes;
    assign cmd_start_o  = r_cmd_start;

    a_rdata_idle_zero: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(cfg_req_i.valid && cfg_req_i.rwn) |-> cfg_rdata_o == '0);

endmodule

//--- hw/filt_launch_seq.sv
// Launch sequencer for the filter.
// A start strobe copies the shadow setting into the active bank and
// pulses filter_start_o one cycle later. Commands seen while the
// filter runs collapse into a single pending relaunch taken on done.

`timescale 1ns/1ns

module filt_launch_seq
(
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     cmd_start_i,
    input  logic                     filter_done_i,
    input  filt_ctrl_pkg::filt_cfg_t shadow_cfg_i,
    output filt_ctrl_pkg::filt_cfg_t active_cfg_o,
    output logic                     filter_start_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_SAMPLE, ST_BUSY} state_e;

    state_e                   r_state;
    state_e                   s_state;
    logic                     s_sample;
    logic                     s_set_pending;
    logic                     s_clr_pending;
    logic                     r_pending;
    filt_ctrl_pkg::filt_cfg_t r_active;

    always_comb
    begin
        s_state       = r_state;
        s_sample      = 1'b0;
        s_set_pending = 1'b0;
        s_clr_pending = 1'b0;
        case (r_state)
            ST_IDLE:
            begin
                if (cmd_start_i)
                begin
                    s_sample = 1'b1;
                    s_state  = ST_SAMPLE;
                end
            end
            ST_SAMPLE:
            begin
                s_set_pending = cmd_start_i;   // Arrived after the copy
                s_state       = ST_BUSY;
            end
            ST_BUSY:
            begin
                if (filter_done_i && (cmd_start_i || r_pending))
                begin
                    s_sample      = 1'b1;
                    s_clr_pending = ~cmd_start_i;
                    s_state       = ST_SAMPLE;
                end
                else if (filter_done_i)
                    s_state = ST_IDLE;
                else if (cmd_start_i)
                    s_set_pending = 1'b1;
            end
            default: s_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_state   <= ST_IDLE;
            r_pending <= 1'b0;
            r_active  <= '0;
        end
        else
        begin
            r_state <= s_state;
            if (s_clr_pending)
                r_pending <= 1'b0;
            else if (s_set_pending)
                r_pending <= 1'b1;
            if (s_sample)
                r_active <= shadow_cfg_i;
        end
    end

    assign filter_start_o = (r_state == ST_SAMPLE);
    assign active_cfg_o   = r_active;

    a_start_single: assert property (@(posedge clk_i) disable iff (!rstn_i)
        filter_start_o |=> !filter_start_o);

    a_active_on_sample: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !$stable(active_cfg_o) |-> $past(s_sample));

endmodule

//--- hw/evt_code_match.sv
// Event code comparator.
// Each stored code is checked independently, so duplicate codes
// raise several bits at once. Purely combinational.

`timescale 1ns/1ns
`include "filt_ctrl_consts.svh"

module evt_code_match
(
    input  logic                          event_valid_i,
    input  logic [7:0]                    event_data_i,
    input  logic [`FILT_NUM_EVT-1:0][7:0] evt_codes_i,
    output logic [`FILT_NUM_EVT-1:0]      event_o
);

    always_comb
    begin
        for (int i = 0; i < `FILT_NUM_EVT; i++)
        begin
            event_o[i] = event_valid_i & (event_data_i == evt_codes_i[i]);
        end
    end

endmodule

//--- hw/filt_ctrl_top.sv
// Configuration block of the filtering engine.
// The bus and the event input have no ready signals and never stall.
// Arithmetic-unit and binarization registers are not implemented.

`timescale 1ns/1ns
`include "filt_ctrl_consts.svh"

module filt_ctrl_top
(
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  filt_ctrl_pkg::cfg_req_t  cfg_req_i,
    output logic [31:0]              cfg_rdata_o,
    output logic [15:0]              cg_value_o,
    output logic                     cg_core_o,
    output logic [15:0]              rst_value_o,
    input  logic                     filter_done_i,
    output logic                     filter_start_o,
    output filt_ctrl_pkg::filt_cfg_t active_cfg_o,
    input  logic                     event_valid_i,
    input  logic [7:0]               event_data_i,
    output logic [`FILT_NUM_EVT-1:0] event_o
);

    filt_ctrl_pkg::filt_cfg_t      shadow_cfg;
    logic [`FILT_NUM_EVT-1:0][7:0] evt_codes;
    logic                          cmd_start;

    filt_cfg_regfile filt_cfg_regfile_inst
    (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .cfg_req_i    (cfg_req_i),
        .cfg_rdata_o  (cfg_rdata_o),
        .cg_value_o   (cg_value_o),
        .cg_core_o    (cg_core_o),
        .rst_value_o  (rst_value_o),
        .shadow_cfg_o (shadow_cfg),
        .evt_codes_o  (evt_codes),
        .cmd_start_o  (cmd_start)
    );

    filt_launch_seq filt_launch_seq_inst
    (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .cmd_start_i    (cmd_start),
        .filter_done_i  (filter_done_i),
        .shadow_cfg_i   (shadow_cfg),
        .active_cfg_o   (active_cfg_o),
        .filter_start_o (filter_start_o)
    );

    evt_code_match evt_code_match_inst
    (
        .event_valid_i (event_valid_i),
        .event_data_i  (event_data_i),
        .evt_codes_i   (evt_codes),
        .event_o       (event_o)
    );

endmodule

//--- include/filt_ctrl_tb_vectors.svh
// Stimulus table for the filter configuration testbench.
// Columns are kind, register address or event code, data, expected value.
// Expected holds the read data for RD steps and the event_o bits for EVT.
// WRND steps take their data from the random generator.
// EVT steps use data bit 0 as valid.
// One step per clock cycle, so launch offsets count in rows.

`ifndef FILT_CTRL_TB_VECTORS_SVH
`define FILT_CTRL_TB_VECTORS_SVH

localparam int NUM_STEPS = 77;

localparam step_t STEPS [NUM_STEPS] = '{
    '{K_WR,   8'(`REG_CG),       32'hFFFF_A5A5, 32'h0000_0000},
    '{K_RD,   8'(`REG_CG),       32'h0000_0000, 32'h0000_A5A5},
    '{K_WR,   8'(`REG_RST),      32'h1234_8001, 32'h0000_0000},
    '{K_RD,   8'(`REG_RST),      32'h0000_0000, 32'h0000_8001},
    '{K_WR,   8'(`REG_CFG_EVT),  32'h3C5A_5A11, 32'h0000_0000},  // Two codes equal
    '{K_RD,   8'(`REG_CFG_EVT),  32'h0000_0000, 32'h3C5A_5A11},
    '{K_WR,   8'(`REG_TX0_ADD),  32'hFFFF_FFFF, 32'h0000_0000},
    '{K_RD,   8'(`REG_TX0_ADD),  32'h0000_0000, 32'h0000_7FFF},
    '{K_WR,   8'(`REG_TX0_CFG),  32'hFFFF_FFFF, 32'h0000_0000},
    '{K_RD,   8'(`REG_TX0_CFG),  32'h0000_0000, 32'h0000_0303},
    '{K_WR,   8'(`REG_TX1_LEN1), 32'hDEAD_BEEF, 32'h0000_0000},
    '{K_RD,   8'(`REG_TX1_LEN1), 32'h0000_0000, 32'h0000_BEEF},
    '{K_WR,   8'(`REG_RX_CFG),   32'h0000_0201, 32'h0000_0000},
    '{K_RD,   8'(`REG_RX_CFG),   32'h0000_0000, 32'h0000_0201},
    '{K_WR,   8'(`REG_TX0_LEN0), 32'h0001_1111, 32'h0000_0000},
    '{K_WR,   8'(`REG_TX0_LEN1), 32'h0002_2222, 32'h0000_0000},
    '{K_WR,   8'(`REG_TX0_LEN2), 32'h0003_3333, 32'h0000_0000},
    '{K_WR,   8'(`REG_TX1_ADD),  32'h0000_C123, 32'h0000_0000},
    '{K_WR,   8'(`REG_TX1_CFG),  32'hFFFF_F1F2, 32'h0000_0000},
    '{K_WR,   8'(`REG_TX1_LEN0), 32'hAAAA_4444, 32'h0000_0000},
    '{K_WR,   8'(`REG_TX1_LEN2), 32'h5555_5555, 32'h0000_0000},
    '{K_WR,   8'(`REG_RX_ADD),   32'h8000_0ABC, 32'h0000_0000},
    '{K_WR,   8'(`REG_RX_LEN0),  32'h0000_6666, 32'h0000_0000},
    '{K_WR,   8'(`REG_RX_LEN1),  32'h0000_7777, 32'h0000_0000},
    '{K_WR,   8'(`REG_RX_LEN2),  32'h0000_8888, 32'h0000_0000},
    '{K_RD,   8'(`REG_TX0_LEN0), 32'h0000_0000, 32'h0000_1111},
    '{K_RD,   8'(`REG_TX0_LEN1), 32'h0000_0000, 32'h0000_2222},
    '{K_RD,   8'(`REG_TX0_LEN2), 32'h0000_0000, 32'h0000_3333},
    '{K_RD,   8'(`REG_TX1_ADD),  32'h0000_0000, 32'h0000_4123},
    '{K_RD,   8'(`REG_TX1_CFG),  32'h0000_0000, 32'h0000_0102},
    '{K_RD,   8'(`REG_TX1_LEN0), 32'h0000_0000, 32'h0000_4444},
    '{K_RD,   8'(`REG_TX1_LEN2), 32'h0000_0000, 32'h0000_5555},
    '{K_RD,   8'(`REG_RX_ADD),   32'h0000_0000, 32'h0000_0ABC},
    '{K_RD,   8'(`REG_RX_LEN0),  32'h0000_0000, 32'h0000_6666},
    '{K_RD,   8'(`REG_RX_LEN1),  32'h0000_0000, 32'h0000_7777},
    '{K_RD,   8'(`REG_RX_LEN2),  32'h0000_0000, 32'h0000_8888},
    '{K_WR,   8'(`REG_FILT),     32'hFFFF_FFFD, 32'h0000_0000},
    '{K_RD,   8'(`REG_FILT),     32'h0000_0000, 32'h0000_0005},
    '{K_WR,   8'd3,              32'hFFFF_FFFF, 32'h0000_0000},  // Reserved slot
    '{K_RD,   8'd3,              32'h0000_0000, 32'h0000_0000},
    '{K_RD,   8'd31,             32'h0000_0000, 32'h0000_0000},
    '{K_WR,   8'(`REG_CG),       32'h0000_0000, 32'h0000_0000},
    '{K_WR,   8'(`REG_FILT_CMD), 32'h0000_0000, 32'h0000_0000},  // Bit 0 clear, no launch
    '{K_WR,   8'(`REG_CG),       32'h0000_0100, 32'h0000_0000},
    '{K_EVT,  8'h11,             32'h0000_0001, 32'h0000_0001},
    '{K_EVT,  8'h5A,             32'h0000_0001, 32'h0000_0006},
    '{K_EVT,  8'h3C,             32'h0000_0001, 32'h0000_0008},
    '{K_EVT,  8'h77,             32'h0000_0001, 32'h0000_0000},
    '{K_EVT,  8'h5A,             32'h0000_0000, 32'h0000_0000},  // Valid low
    '{K_WRND, 8'(`REG_TX0_LEN0), 32'h0000_0000, 32'h0000_0000},
    '{K_WRND, 8'(`REG_RX_ADD),   32'h0000_0000, 32'h0000_0000},
    '{K_WR,   8'(`REG_FILT_CMD), 32'h0000_0001, 32'h0000_0000},  // Launch from idle
    '{K_WRND, 8'(`REG_TX1_CFG),  32'h0000_0000, 32'h0000_0000},  // Too late for this copy
    '{K_IDLE, 8'h00,             32'h0000_0000, 32'h0000_0000},
    '{K_DONE, 8'h00,             32'h0000_0000, 32'h0000_0000},
    '{K_IDLE, 8'h00,             32'h0000_0000, 32'h0000_0000},
    '{K_WR,   8'(`REG_FILT_CMD), 32'h0000_0001, 32'h0000_0000},
    '{K_IDLE, 8'h00,             32'h0000_0000, 32'h0000_0000},
    '{K_IDLE, 8'h00,             32'h0000_0000, 32'h0000_0000},
    '{K_WR,   8'(`REG_FILT_CMD), 32'h0000_0001, 32'h0000_0000},  // While busy
    '{K_WRND, 8'(`REG_RX_LEN0),  32'h0000_0000, 32'h0000_0000},
    '{K_WR,   8'(`REG_FILT_CMD), 32'h0000_0003, 32'h0000_0000},  // Merges with pending
    '{K_WRND, 8'(`REG_FILT),     32'h0000_0000, 32'h0000_0000},
    '{K_DONE, 8'h00,             32'h0000_0000, 32'h0000_0000},
    '{K_IDLE, 8'h00,             32'h0000_0000, 32'h0000_0000},
    '{K_DONE, 8'h00,             32'h0000_0000, 32'h0000_0000},
    '{K_IDLE, 8'h00,             32'h0000_0000, 32'h0000_0000},
    '{K_WR,   8'(`REG_FILT_CMD), 32'h0000_0001, 32'h0000_0000},
    '{K_IDLE, 8'h00,             32'h0000_0000, 32'h0000_0000},
    '{K_IDLE, 8'h00,             32'h0000_0000, 32'h0000_0000},
    '{K_WRND, 8'(`REG_TX0_ADD),  32'h0000_0000, 32'h0000_0000},
    '{K_WR,   8'(`REG_FILT_CMD), 32'h0000_0001, 32'h0000_0000},
    '{K_DONE, 8'h00,             32'h0000_0000, 32'h0000_0000},  // Same cycle as command
    '{K_IDLE, 8'h00,             32'h0000_0000, 32'h0000_0000},
    '{K_DONE, 8'h00,             32'h0000_0000, 32'h0000_0000},
    '{K_IDLE, 8'h00,             32'h0000_0000, 32'h0000_0000},
    '{K_IDLE, 8'h00,             32'h0000_0000, 32'h0000_0000}
};

`endif

//--- bench/filt_ctrl_tb.sv
// Testbench for the filter configuration block.
// Table steps run one per clock cycle; inputs change on the rising
// edge and outputs are sampled on the falling edge.
// A local model of the shadow set, the active set and the launch
// timing gives the expected start strobe and active setting.

`timescale 1ns/1ns
`include "filt_ctrl_consts.svh"

module filt_ctrl_tb;

    typedef struct packed
    {
        logic [2:0]  kind;
        logic [7:0]  addr;                     // Register address or event code
        logic [31:0] data;
        logic [31:0] exp;
    } step_t;

    localparam logic [2:0] K_IDLE = 3'd0;
    localparam logic [2:0] K_WR   = 3'd1;
    localparam logic [2:0] K_WRND = 3'd2;
    localparam logic [2:0] K_RD   = 3'd3;
    localparam logic [2:0] K_DONE = 3'd4;
    localparam logic [2:0] K_EVT  = 3'd5;

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_BUSY  = 2'd2;

`include "filt_ctrl_tb_vectors.svh"

    localparam int TIMEOUT_CYCLES = NUM_STEPS * 4 + 50;

    logic                     clk_i;
    logic                     rstn_i;
    filt_ctrl_pkg::cfg_req_t  cfg_req_i;
    logic [31:0]              cfg_rdata_o;
    logic [15:0]              cg_value_o;
    logic                     cg_core_o;
    logic [15:0]              rst_value_o;
    logic                     filter_done_i;
    logic                     filter_start_o;
    filt_ctrl_pkg::filt_cfg_t active_cfg_o;
    logic                     event_valid_i;
    logic [7:0]               event_data_i;
    logic [`FILT_NUM_EVT-1:0] event_o;

    // Reference model
    filt_ctrl_pkg::filt_cfg_t m_shadow;
    filt_ctrl_pkg::filt_cfg_t m_active;
    logic [15:0]              m_cg;
    logic [15:0]              m_rst;
    logic [1:0]               m_state;
    logic                     m_pending;
    logic                     m_cmd_d;           // Command strobe seen this cycle

    integer                   seed;
    int                       errors;
    int                       cycles = 0;

    filt_ctrl_top filt_ctrl_top_inst
    (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .cfg_req_i      (cfg_req_i),
        .cfg_rdata_o    (cfg_rdata_o),
        .cg_value_o     (cg_value_o),
        .cg_core_o      (cg_core_o),
        .rst_value_o    (rst_value_o),
        .filter_done_i  (filter_done_i),
        .filter_start_o (filter_start_o),
        .active_cfg_o   (active_cfg_o),
        .event_valid_i  (event_valid_i),
        .event_data_i   (event_data_i),
        .event_o        (event_o)
    );

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, the step table did not finish", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Model updates
    //////////////////////////////////////////////////////////////////////
    task automatic model_write(input logic [4:0] addr, input logic [31:0] data);
        filt_ctrl_pkg::chan_cfg_t ch;
        int rel;
        int idx;
        rel = int'(addr) - int'(`REG_TX0_ADD);
        if (addr == `REG_CG)
            m_cg = data[15:0];
        else if (addr == `REG_RST)
            m_rst = data[15:0];
        else if (addr == `REG_FILT)
            m_shadow.filter_mode = data[2:0];
        else if (rel >= 0 && rel < 15)
        begin
            idx = rel / 5;                       // 0 tx0, 1 tx1, 2 rx
            ch  = (idx == 2) ? m_shadow.rx : m_shadow.tx[idx[0]];
            case (rel % 5)
                0: ch.start_addr = data[`FILT_L2_AWIDTH-1:0];
                1:
                begin
                    ch.datasize = data[1:0];
                    ch.mode     = data[9:8];
                end
                2: ch.len0 = data[15:0];
                3: ch.len1 = data[15:0];
                default: ch.len2 = data[15:0];
            endcase
            if (idx == 2)
                m_shadow.rx = ch;
            else
                m_shadow.tx[idx[0]] = ch;
        end
    endtask

    task automatic advance_launch_model(input logic cmd_wr, input logic done);
        case (m_state)
            S_IDLE:
            begin
                if (m_cmd_d)
                begin
                    m_active = m_shadow;
                    m_state  = S_START;
                end
            end
            S_START:
            begin
                if (m_cmd_d)
                    m_pending = 1'b1;
                m_state = S_BUSY;
            end
            default:
            begin
                if (done && (m_cmd_d || m_pending))
                begin
                    m_active = m_shadow;
                    if (!m_cmd_d)
                        m_pending = 1'b0;
                    m_state = S_START;
                end
                else if (done)
                    m_state = S_IDLE;
                else if (m_cmd_d)
                    m_pending = 1'b1;
            end
        endcase
        m_cmd_d = cmd_wr;                        // Register stage in front of the FSM
    endtask

    task automatic check_outputs(input step_t st);
        logic        exp_start;
        logic [31:0] exp_rdata;
        logic [3:0]  exp_event;
        exp_start = (m_state == S_START);
        exp_rdata = (st.kind == K_RD) ? st.exp : 32'h0;
        exp_event = (st.kind == K_EVT) ? st.exp[3:0] : 4'h0;
        if (filter_start_o !== exp_start)
        begin
            errors++;
            $display("** Error at %0t ns: filter_start_o expected %b, got %b",
                     $time, exp_start, filter_start_o);
        end
        if (active_cfg_o !== m_active)
        begin
            errors++;
            $display("** Error at %0t ns: active_cfg_o expected %h, got %h",
                     $time, m_active, active_cfg_o);
        end
        if (cfg_rdata_o !== exp_rdata)
        begin
            errors++;
            $display("** Error at %0t ns: cfg_rdata_o expected %h, got %h",
                     $time, exp_rdata, cfg_rdata_o);
        end
        if (event_o !== exp_event)
        begin
            errors++;
            $display("** Error at %0t ns: event_o expected %b, got %b",
                     $time, exp_event, event_o);
        end
        if (cg_value_o !== m_cg)
        begin
            errors++;
            $display("** Error at %0t ns: cg_value_o expected %h, got %h",
                     $time, m_cg, cg_value_o);
        end
        if (cg_core_o !== (|m_cg))
        begin
            errors++;
            $display("** Error at %0t ns: cg_core_o expected %b, got %b",
                     $time, |m_cg, cg_core_o);
        end
        if (rst_value_o !== m_rst)
        begin
            errors++;
            $display("** Error at %0t ns: rst_value_o expected %h, got %h",
                     $time, m_rst, rst_value_o);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////
    initial
    begin
        step_t                   st;
        filt_ctrl_pkg::cfg_req_t req;
        logic [31:0]             wdata;
        logic                    cmd_wr;
        seed          = 32'h23e1d577;
        errors        = 0;
        clk_i         = 1'b0;
        rstn_i        = 1'b0;
        cfg_req_i     = '0;
        filter_done_i = 1'b0;
        event_valid_i = 1'b0;
        event_data_i  = 8'h00;
        m_shadow      = '0;
        m_active      = '0;
        m_cg          = 16'h0;
        m_rst         = 16'h0;
        m_state       = S_IDLE;
        m_pending     = 1'b0;
        m_cmd_d       = 1'b0;

        repeat (3) @(posedge clk_i);
        rstn_i <= 1'b1;

        for (int i = 0; i < NUM_STEPS; i++)
        begin
            st = STEPS[i];
            @(posedge clk_i);
            wdata     = (st.kind == K_WRND) ? $random(seed) : st.data;
            req       = '0;
            req.valid = (st.kind == K_WR || st.kind == K_WRND || st.kind == K_RD);
            req.rwn   = (st.kind == K_RD);
            req.addr  = st.addr[4:0];
            req.wdata = wdata;
            cfg_req_i     <= req;
            filter_done_i <= (st.kind == K_DONE);
            event_valid_i <= (st.kind == K_EVT) && st.data[0];
            event_data_i  <= st.addr;

            @(negedge clk_i);
            check_outputs(st);
            cmd_wr = req.valid && !req.rwn && req.addr == `REG_FILT_CMD && wdata[0];
            advance_launch_model(cmd_wr, st.kind == K_DONE);
            if (req.valid && !req.rwn)
                model_write(req.addr, wdata);    // Lands after the copy of this cycle
        end

        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- sim.f
+incdir+include
hw/filt_ctrl_pkg.sv
hw/filt_cfg_regfile.sv
hw/filt_launch_seq.sv
hw/evt_code_match.sv
hw/filt_ctrl_top.sv
bench/filt_ctrl_tb.sv

//--- Makefile
# Verilator build and run for the filter configuration block

VERILATOR ?= verilator
TOP       ?= filt_ctrl_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

PASS_MSG  := TEST RESULT: PASS
SOURCES   := $(FILELIST) $(wildcard hw/*.sv bench/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
